// File: source/rv_core_pkg.sv
package rv_core_pkg;

  parameter int xlen       = 32; // data and address width
  parameter int reg_addr_w = 5;  // register index width

  parameter logic [xlen-1:0] reset_vector = 32'h8000_0000;

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    op_lui    = 7'b011_0111,
    op_auipc  = 7'b001_0111,
    op_jal    = 7'b110_1111,
    op_jalr   = 7'b110_0111,
    op_load   = 7'b000_0011,
    op_store  = 7'b010_0011,
    op_imm    = 7'b001_0011,
    op_system = 7'b111_0011,
    op_other  = 7'b000_0000  // anything not implemented, runs as a no-op
  } opcode_e;

  // funct3 of loads and stores
  typedef enum logic [2:0] {
    sz_b  = 3'b000,
    sz_h  = 3'b001,
    sz_w  = 3'b010,
    sz_bu = 3'b100,
    sz_hu = 3'b101
  } mem_size_e;

endpackage

// File: source/pc_unit.sv
`timescale 1ns/1ns

module pc_unit #(
  parameter logic [rv_core_pkg::xlen-1:0] reset_pc = rv_core_pkg::reset_vector
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         jump,
  input  logic [rv_core_pkg::xlen-1:0] target,
  input  logic                         is_ebreak,
  output logic [rv_core_pkg::xlen-1:0] pc,
  output logic [rv_core_pkg::xlen-1:0] next_pc,
  output logic                         halt
);
  import rv_core_pkg::*;

  assign next_pc = pc + xlen'(4); // static next pc

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc   <= reset_pc;
      halt <= 1'b0;
    end else if (!halt) begin
      if (is_ebreak) begin
        halt <= 1'b1; // pc stays on the ebreak
      end else begin
        pc <= jump ? target : next_pc;
      end
    end
  end

  // targets come from the adder, so this also covers jal/jalr offsets
  pc_aligned_a: assert property (
    @(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00
  ) else $error("pc not word aligned: %h", pc);

endmodule

// File: source/inst_decode.sv
`timescale 1ns/1ns

module inst_decode (
  input  logic [rv_core_pkg::xlen-1:0]       inst,
  output rv_core_pkg::opcode_e               opcode,
  output rv_core_pkg::mem_size_e             size,
  output logic [rv_core_pkg::reg_addr_w-1:0] rs1,
  output logic [rv_core_pkg::reg_addr_w-1:0] rs2,
  output logic [rv_core_pkg::reg_addr_w-1:0] rd,
  output logic [rv_core_pkg::xlen-1:0]       imm,
  output logic                               reg_we,
  output logic                               mem_re,
  output logic                               mem_we,
  output logic                               jump,
  output logic                               use_pc,
  output logic                               is_ebreak
);
  import rv_core_pkg::*;

  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;

  assign rs1  = inst[19:15];
  assign rs2  = inst[24:20];
  assign rd   = inst[11:7];
  assign size = mem_size_e'(inst[14:12]);

  // known opcodes pass through, the rest collapse to op_other
  always_comb begin
    case (inst[6:0])
      op_lui, op_auipc, op_jal, op_jalr,
      op_load, op_store, op_imm, op_system: opcode = opcode_e'(inst[6:0]);
      default:                              opcode = op_other;
    endcase
  end

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {inst[31:12], 12'h000}; // already shifted
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    case (opcode)
      op_lui, op_auipc: imm = imm_u;
      op_jal:           imm = imm_j;
      op_store:         imm = imm_s;
      default:          imm = imm_i; // op-imm, load, jalr
    endcase
  end

  assign reg_we = opcode inside {op_lui, op_auipc, op_jal, op_jalr, op_load, op_imm};
  assign mem_re = (opcode == op_load);
  assign mem_we = (opcode == op_store);
  assign jump   = (opcode == op_jal) || (opcode == op_jalr);
  assign use_pc = (opcode == op_auipc) || (opcode == op_jal);

  // only the exact ebreak encoding halts, ecall and csr ops do nothing
  assign is_ebreak = (opcode == op_system) && (inst[31:20] == 12'h001)
                     && (inst[19:7] == '0);

  always_comb begin
    mem_dir_a: assert (!(mem_re && mem_we))
      else $error("load and store decoded together: %h", inst);
  end

endmodule

// File: source/reg_file.sv
`timescale 1ns/1ns

module reg_file #(
  parameter int nr_regs = 32
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               we,
  input  logic [rv_core_pkg::reg_addr_w-1:0] waddr,
  input  logic [rv_core_pkg::reg_addr_w-1:0] raddr1,
  input  logic [rv_core_pkg::reg_addr_w-1:0] raddr2,
  input  logic [rv_core_pkg::xlen-1:0]       wdata,
  output logic [rv_core_pkg::xlen-1:0]       rdata1,
  output logic [rv_core_pkg::xlen-1:0]       rdata2
);
  import rv_core_pkg::*;

  localparam int idx_w = $clog2(nr_regs);

  logic [xlen-1:0] regs [nr_regs];

  // x0 and indices past the file read as zero
  function automatic logic [xlen-1:0] read_reg(input logic [reg_addr_w-1:0] a);
    if (a == '0 || int'(a) >= nr_regs) begin
      return '0;
    end
    return regs[a[idx_w-1:0]];
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < nr_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0 && int'(waddr) < nr_regs) begin
      regs[waddr[idx_w-1:0]] <= wdata;
    end
  end

  assign rdata1 = read_reg(raddr1);
  assign rdata2 = read_reg(raddr2);

endmodule

// File: source/exec_unit.sv
`timescale 1ns/1ns

module exec_unit (
  input  rv_core_pkg::opcode_e         opcode,
  input  logic [rv_core_pkg::xlen-1:0] pc,
  input  logic [rv_core_pkg::xlen-1:0] rs1_data,
  input  logic [rv_core_pkg::xlen-1:0] imm,
  input  logic [rv_core_pkg::xlen-1:0] next_pc,
  input  logic [rv_core_pkg::xlen-1:0] load_data,
  output logic [rv_core_pkg::xlen-1:0] sum,
  output logic [rv_core_pkg::xlen-1:0] target,
  output logic [rv_core_pkg::xlen-1:0] wb_data
);
  import rv_core_pkg::*;

  logic [xlen-1:0] op_a;

  always_comb begin
    case (opcode)
      op_auipc, op_jal: op_a = pc;
      op_lui:           op_a = '0; // lui is just 0 + imm_u
      default:          op_a = rs1_data;
    endcase
  end

  // one adder for address, jump target and arithmetic
  assign sum = op_a + imm;

  assign target = {sum[xlen-1:1], 1'b0}; // jalr drops bit 0

  always_comb begin
    case (opcode)
      op_jal, op_jalr: wb_data = next_pc; // link
      op_load:         wb_data = load_data;
      default:         wb_data = sum;
    endcase
  end

endmodule

// File: source/load_store_unit.sv
`timescale 1ns/1ns

module load_store_unit (
  input  logic [rv_core_pkg::xlen-1:0] addr,
  input  rv_core_pkg::mem_size_e       size,
  input  logic                         load,
  input  logic                         store,
  input  logic [rv_core_pkg::xlen-1:0] rs2_data,
  input  logic [rv_core_pkg::xlen-1:0] mem_rdata,
  output logic [rv_core_pkg::xlen-1:0] load_data,
  output logic [rv_core_pkg::xlen-1:0] mem_addr,
  output logic                         mem_re,
  output logic                         mem_we,
  output logic [3:0]                   mem_wmask,
  output logic [rv_core_pkg::xlen-1:0] mem_wdata
);
  import rv_core_pkg::*;

  logic [1:0]  off;
  logic [7:0]  lane_b;
  logic [15:0] lane_h;

  assign off      = addr[1:0];
  assign mem_addr = {addr[xlen-1:2], 2'b00};

  // byte lanes, zero when misaligned
  always_comb begin
    mem_wmask = 4'b0000;
    case (size)
      sz_b:    mem_wmask = 4'b0001 << off;
      sz_h:    mem_wmask = off[0] ? 4'b0000 : (4'b0011 << off);
      sz_w:    mem_wmask = (off == 2'b00) ? 4'b1111 : 4'b0000;
      default: mem_wmask = 4'b0000;
    endcase
  end

  // value copied into every lane, the mask picks the right one
  always_comb begin
    case (size)
      sz_b:    mem_wdata = {4{rs2_data[7:0]}};
      sz_h:    mem_wdata = {2{rs2_data[15:0]}};
      default: mem_wdata = rs2_data;
    endcase
  end

  assign mem_we = store && (mem_wmask != 4'b0000);
  assign mem_re = load;

  assign lane_b = mem_rdata[{off, 3'b000} +: 8];
  assign lane_h = off[1] ? mem_rdata[31:16] : mem_rdata[15:0];

  always_comb begin
    load_data = '0;
    case (size)
      sz_b:  load_data = {{24{lane_b[7]}}, lane_b};
      sz_bu: load_data = {24'h00_0000, lane_b};
      sz_h:  load_data = off[0] ? '0 : {{16{lane_h[15]}}, lane_h};
      sz_hu: load_data = off[0] ? '0 : {16'h0000, lane_h};
      sz_w:  load_data = (off == 2'b00) ? mem_rdata : '0;
      default: load_data = '0;
    endcase
  end

  always_comb begin
    wmask_a: assert (!mem_we || mem_wmask != 4'b0000)
      else $error("store with empty byte mask at %h", addr);
  end

endmodule

// File: source/rv_core_top.sv
`timescale 1ns/1ns

module rv_core_top #(
  parameter logic [rv_core_pkg::xlen-1:0] reset_pc = rv_core_pkg::reset_vector,
  parameter int                           nr_regs  = 32
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [rv_core_pkg::xlen-1:0] inst,
  input  logic [rv_core_pkg::xlen-1:0] mem_rdata,
  output logic [rv_core_pkg::xlen-1:0] pc,
  output logic [rv_core_pkg::xlen-1:0] mem_addr,
  output logic                         mem_re,
  output logic                         mem_we,
  output logic [3:0]                   mem_wmask,
  output logic [rv_core_pkg::xlen-1:0] mem_wdata,
  output logic                         halt
);
  import rv_core_pkg::*;

  opcode_e               opcode;
  mem_size_e             size;
  logic [reg_addr_w-1:0] rs1;
  logic [reg_addr_w-1:0] rs2;
  logic [reg_addr_w-1:0] rd;
  logic [xlen-1:0]       imm;
  logic                  dec_reg_we;
  logic                  dec_mem_re;
  logic                  dec_mem_we;
  logic                  jump;
  logic                  use_pc;
  logic                  is_ebreak;
  logic [xlen-1:0]       rs1_data;
  logic [xlen-1:0]       rs2_data;
  logic [xlen-1:0]       sum;
  logic [xlen-1:0]       target;
  logic [xlen-1:0]       wb_data;
  logic [xlen-1:0]       load_data;
  logic [xlen-1:0]       next_pc;
  logic                  reg_we;
  logic                  store;

  assign reg_we = dec_reg_we && !halt; // no side effects once halted
  assign store  = dec_mem_we && !halt;

  pc_unit #(.reset_pc(reset_pc)) pc_unit_i (
    .clk, .rst_n, .jump, .target, .is_ebreak, .pc, .next_pc, .halt
  );

  inst_decode inst_decode_i (
    .inst, .opcode, .size, .rs1, .rs2, .rd, .imm,
    .reg_we(dec_reg_we), .mem_re(dec_mem_re), .mem_we(dec_mem_we),
    .jump, .use_pc, .is_ebreak
  );

  reg_file #(.nr_regs(nr_regs)) reg_file_i (
    .clk, .rst_n, .we(reg_we), .waddr(rd), .raddr1(rs1), .raddr2(rs2),
    .wdata(wb_data), .rdata1(rs1_data), .rdata2(rs2_data)
  );

  exec_unit exec_unit_i (
    .opcode, .pc, .rs1_data, .imm, .next_pc, .load_data, .sum, .target, .wb_data
  );

  load_store_unit load_store_unit_i (
    .addr(sum), .size, .load(dec_mem_re), .store, .rs2_data, .mem_rdata,
    .load_data, .mem_addr, .mem_re, .mem_we, .mem_wmask, .mem_wdata
  );

  // jal lands exactly pc + imm_j one cycle later
  jal_target_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    !halt && jump && use_pc |=> pc == $past(pc + imm)
  ) else $error("jal went to %h", pc);

  // ebreak freezes the core from the following edge on
  ebreak_halt_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    is_ebreak && !halt |=> halt && $stable(pc)
  ) else $error("ebreak did not halt the core");

endmodule

// File: test/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// instruction kinds of the stimulus
localparam int k_lui    = 0;
localparam int k_auipc  = 1;
localparam int k_addi   = 2;
localparam int k_jal    = 3;
localparam int k_jalr   = 4;
localparam int k_load   = 5;
localparam int k_store  = 6;
localparam int k_ebreak = 7;

localparam logic [31:0] data_base = 32'h0001_0000;
localparam int          mem_words = 256;

logic [31:0] m_regs [32];
logic [31:0] m_pc;
logic [31:0] m_mem [mem_words];
logic [31:0] env_mem [mem_words]; // what the dut sees on mem_rdata
int          m_src [32];          // 1 after a load, 2 after a link or immediate
logic [31:0] rng_state;

function automatic logic [31:0] xorshift32();
  logic [31:0] x;
  x = rng_state;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  rng_state = x;
  return x;
endfunction

function automatic logic [31:0] fill_word(input logic [31:0] addr);
  return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
endfunction

function automatic int word_index(input logic [31:0] addr);
  logic [31:0] rel;
  rel = addr - data_base;
  return int'(rel[9:2]);
endfunction

task automatic model_reset();
  m_pc = 32'h8000_0000;
  for (int i = 0; i < 32; i++) begin
    m_regs[i] = 32'd0;
    m_src[i]  = 0;
  end
  for (int i = 0; i < mem_words; i++) begin
    m_mem[i]   = fill_word(data_base + 32'(4 * i));
    env_mem[i] = m_mem[i];
  end
endtask

// byte or half picked by the low address bits, then extended per funct3
function automatic logic [31:0] model_load(input logic [2:0] f3, input logic [31:0] addr);
  logic [31:0] w;
  logic [7:0]  b;
  logic [15:0] h;
  w = m_mem[word_index(addr)];
  b = w[8 * int'(addr[1:0]) +: 8];
  h = addr[1] ? w[31:16] : w[15:0];
  case (f3)
    3'b000:  return {{24{b[7]}}, b};
    3'b001:  return {{16{h[15]}}, h};
    3'b100:  return {24'd0, b};
    3'b101:  return {16'd0, h};
    default: return w;
  endcase
endfunction

task automatic model_step(input int kind, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [4:0] rs2, input logic [2:0] f3,
                          input logic [31:0] imm);
  logic [31:0] ea;
  logic [31:0] res;
  logic [31:0] nxt;
  int          src;
  int          nbytes;
  ea     = m_regs[rs1] + imm;
  nxt    = m_pc + 32'd4;
  res    = nxt; // link value
  src    = 2;
  nbytes = 1 << f3[1:0];
  case (kind)
    k_lui:   res = imm;
    k_auipc: res = m_pc + imm;
    k_addi:  res = ea;
    k_jal:   nxt = m_pc + imm;
    k_jalr:  nxt = ea & ~32'd1;
    k_load: begin
      res = model_load(f3, ea);
      src = 1;
    end
    k_store: begin
      src = 0;
      for (int i = 0; i < nbytes; i++) begin
        m_mem[word_index(ea)][8 * (int'(ea[1:0]) + i) +: 8] = m_regs[rs2][8 * i +: 8];
      end
    end
    default: begin
      src = 0;
      nxt = m_pc; // ebreak holds the pc
    end
  endcase
  if (src != 0 && rd != 5'd0) begin
    m_regs[rd] = res;
    m_src[rd]  = src;
  end
  m_pc = nxt;
endtask

`endif

// File: test/tb_rv_core.sv
`timescale 1ns/1ns

module tb_rv_core;

  localparam int reset_cycles = 10;
  localparam int n_random     = 2000;
  localparam int halt_cycles  = 5;
  // reset, the random run, ebreak and the halt window, plus slack
  localparam int max_cycles   = reset_cycles + n_random + halt_cycles + 85;

  localparam logic [2:0] load_f3 [5] = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
  localparam logic [2:0] store_f3 [3] = '{3'b000, 3'b001, 3'b010};

  logic        clk;
  logic        rst_n;
  logic [31:0] inst;
  logic [31:0] mem_rdata;
  logic [31:0] pc;
  logic [31:0] mem_addr;
  logic        mem_re;
  logic        mem_we;
  logic [3:0]  mem_wmask;
  logic [31:0] mem_wdata;
  logic        halt;

  int          g_kind;
  logic [4:0]  g_rd;
  logic [4:0]  g_rs1;
  logic [4:0]  g_rs2;
  logic [2:0]  g_f3;
  logic [31:0] g_imm;
  logic [31:0] halt_pc;
  int          n_checks [1:6] = '{default: 0};
  int          n_fails [1:6] = '{default: 0};
  int          total_checks;
  int          total_fails;
  int          cycle_count = 0;

  `include "tb_ref_model.svh"

  rv_core_top #(.reset_pc(32'h8000_0000), .nr_regs(32)) dut_i (
    .clk, .rst_n, .inst, .mem_rdata, .pc, .mem_addr, .mem_re, .mem_we,
    .mem_wmask, .mem_wdata, .halt
  );

  assign mem_rdata = env_mem[word_index(mem_addr)];

  always #20 clk = ~clk;

  function automatic logic [31:0] byte_mask(input logic [3:0] m);
    return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
  endfunction

  // store commits at the edge that closes the cycle
  always @(posedge clk) begin
    if (rst_n && mem_we) begin
      env_mem[word_index(mem_addr)] = (env_mem[word_index(mem_addr)] & ~byte_mask(mem_wmask))
                                      | (mem_wdata & byte_mask(mem_wmask));
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= max_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", max_cycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] encode_current();
    case (g_kind)
      k_lui:   return {g_imm[31:12], g_rd, 7'b011_0111};
      k_auipc: return {g_imm[31:12], g_rd, 7'b001_0111};
      k_addi:  return {g_imm[11:0], g_rs1, 3'b000, g_rd, 7'b001_0011};
      k_jal:   return {g_imm[20], g_imm[10:1], g_imm[11], g_imm[19:12], g_rd, 7'b110_1111};
      k_jalr:  return {g_imm[11:0], g_rs1, 3'b000, g_rd, 7'b110_0111};
      k_load:  return {g_imm[11:0], g_rs1, g_f3, g_rd, 7'b000_0011};
      k_store: return {g_imm[11:5], g_rs2, g_rs1, g_f3, g_imm[4:0], 7'b010_0011};
      default: return 32'h0010_0073; // ebreak
    endcase
  endfunction

  task automatic pick_instr();
    logic [31:0] r;
    logic [31:0] r2;
    logic [31:0] off;
    r     = xorshift32();
    r2    = xorshift32();
    off   = {22'd0, r[19:12], 2'b00}; // word offset inside the data region
    g_rd  = (r[4:0] == 5'd1) ? 5'd31 : r[4:0]; // x1 keeps the data base
    g_rs1 = 5'd1;
    g_rs2 = r[9:5];
    g_f3  = 3'b000;
    g_imm = {r2[31:12], 12'h000};
    case (int'(r[31:28]))
      0, 1:    g_kind = k_lui;
      2:       g_kind = k_auipc;
      3, 4, 5: begin
        g_kind = k_addi;
        g_rs1  = r[14:10];
        g_imm  = {{20{r2[11]}}, r2[11:0]};
      end
      6: begin
        g_kind = k_jal;
        g_imm  = {{20{r2[11]}}, r2[11:2], 2'b00};
      end
      7: begin
        g_kind = k_jalr;
        g_imm  = off | {31'd0, r2[0]}; // odd offset, bit 0 gets dropped
      end
      8, 9, 10: begin
        g_kind = k_load;
        g_f3   = load_f3[int'(r2[7:0]) % 5];
      end
      default: begin
        g_kind = k_store;
        g_f3   = store_f3[int'(r2[7:0]) % 3];
      end
    endcase
    if (g_kind == k_load || g_kind == k_store) begin
      // byte keeps both low bits, half only bit 1, word none
      g_imm = off | {30'd0, r2[9:8] & {~g_f3[1], ~g_f3[1] & ~g_f3[0]}};
    end
  endtask

  task automatic check_eq(input int beh, input string name, input logic [31:0] got,
                          input logic [31:0] exp);
    n_checks[beh]++;
    assert (got === exp) else begin
      n_fails[beh]++;
      $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_outputs();
    logic [31:0] ea;
    logic [3:0]  mask;
    int          beh;
    check_eq(2, "pc", pc, m_pc);
    check_eq(3, "mem_re", 32'(mem_re), (g_kind == k_load) ? 32'd1 : 32'd0);
    if (g_kind == k_store) begin
      ea   = m_regs[g_rs1] + g_imm;
      mask = (g_f3 == 3'b000) ? 4'b0001 << ea[1:0] :
             (g_f3 == 3'b001) ? 4'b0011 << ea[1:0] : 4'b1111;
      beh  = (m_src[g_rs2] == 2) ? 5 : (m_src[g_rs2] == 1 && g_f3 == 3'b010) ? 4 : 3;
      check_eq(3, "mem_we", 32'(mem_we), 32'd1);
      check_eq(3, "mem_addr", mem_addr, {ea[31:2], 2'b00});
      check_eq(3, "mem_wmask", 32'(mem_wmask), 32'(mask));
      check_eq(beh, "mem_wdata", mem_wdata & byte_mask(mask),
               (m_regs[g_rs2] << (8 * ea[1:0])) & byte_mask(mask));
    end else begin
      check_eq(3, "mem_we", 32'(mem_we), 32'd0);
    end
  endtask

  // drive, check before the edge, then let the model take the same step
  task automatic step_instr();
    inst = encode_current();
    @(negedge clk);
    check_outputs();
    model_step(g_kind, g_rd, g_rs1, g_rs2, g_f3, g_imm);
    @(posedge clk);
    #1;
  endtask

  task automatic report(input int beh, input string name);
    if (n_checks[beh] == 0) begin
      $display("behavior %0d (%s): no checks were made", beh, name);
      n_fails[beh]++;
    end
    $display("behavior %0d (%s): %0d checks, %0d failed", beh, name, n_checks[beh],
             n_fails[beh]);
  endtask

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    inst      = 32'h0000_0013; // addi x0,x0,0
    rng_state = 32'h5a30_8d5b;
    model_reset();
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_eq(1, "pc", pc, 32'h8000_0000);
    check_eq(1, "halt", 32'(halt), 32'd0);
    check_eq(1, "mem_we", 32'(mem_we), 32'd0);
    report(1, "reset");

    g_kind = k_lui;
    g_rd   = 5'd1;
    g_imm  = data_base;
    step_instr();
    repeat (n_random) begin
      pick_instr();
      step_instr();
    end
    report(2, "sequencing and jumps");
    report(3, "stores");
    report(4, "load extension");
    report(5, "links and immediates");

    g_kind = k_ebreak;
    step_instr();
    check_eq(6, "halt", 32'(halt), 32'd1);
    check_eq(6, "pc", pc, m_pc);
    halt_pc = pc;
    repeat (halt_cycles) begin
      pick_instr();
      g_kind = k_store; // stores must stay blocked
      g_f3   = 3'b010;
      g_imm  = 32'd0;
      inst   = encode_current();
      @(negedge clk);
      check_eq(6, "pc", pc, halt_pc);
      check_eq(6, "halt", 32'(halt), 32'd1);
      check_eq(6, "mem_we", 32'(mem_we), 32'd0);
      @(posedge clk);
      #1;
    end
    report(6, "halt");

    total_checks = 0;
    total_fails  = 0;
    for (int b = 1; b <= 6; b++) begin
      total_checks += n_checks[b];
      total_fails  += n_fails[b];
    end
    $display("summary: %0d checks, %0d failed", total_checks, total_fails);
    if (total_fails == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: files.f
+incdir+test
source/rv_core_pkg.sv
source/pc_unit.sv
source/inst_decode.sv
source/reg_file.sv
source/exec_unit.sv
source/load_store_unit.sv
source/rv_core_top.sv
test/tb_rv_core.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, pass only on the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_rv_core -f files.f \
  || { echo "verilator build failed"; exit 1; }
./obj_dir/Vtb_rv_core | tee /dev/stderr | grep -x "ALL CHECKS PASSED" > /dev/null \
  && echo "simulation ok" || { echo "simulation not ok"; exit 1; }
